//--- ps2_keyboard.f
source/kbd_pkg.sv
source/ps2_receiver.sv
source/scan_code_parser.sv
source/key_state_table.sv
source/keyboard_parser.sv
verification/ps2_device_model.sv
verification/tb_keyboard_parser.sv

//--- run_sim.sh
#!/bin/sh
# Builds the keyboard parser testbench with Verilator and runs it.
# The exit status is nonzero when the build fails or the log reports a failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_keyboard_parser \
	-f ps2_keyboard.f \
	-o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed."
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status."
	exit 1
fi
exit 0

//--- source/kbd_pkg.sv
`default_nettype none

package kbd_pkg;

	// One byte as it arrives from the keyboard.
	typedef logic [7:0] scan_code_t;

	// Ordinary codes stay below 0x80, so seven bits address a key.
	typedef logic [6:0] key_index_t;

	// One bit per key; a set bit means the key is held down.
	typedef logic [2**$bits(key_index_t)-1:0] key_map_t;

	localparam scan_code_t PREFIX_EXTENDED = 8'hE0; // Extended key follows.
	localparam scan_code_t PREFIX_BREAK    = 8'hF0; // Key release follows.

	// Start, eight data bits, parity, stop.
	localparam int PS2_FRAME_BITS = 11;

	typedef struct packed {
		key_index_t index;
		logic       extended; // Sequence carried the E0 prefix.
		logic       released; // Sequence carried the F0 prefix.
	} key_event_t;

endpackage

`default_nettype wire

//--- source/key_state_table.sv
`timescale 1ns/1ns
`default_nettype none

module key_state_table (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      key_event_valid,
	input  wire kbd_pkg::key_event_t key_event,
	output kbd_pkg::key_map_t        key_data,
	output kbd_pkg::key_map_t        extended_key_data
);
	import kbd_pkg::*;

	logic key_pressed;

	assign key_pressed = !key_event.released;

	// The extended flag picks the map, the release flag the new bit value.
	always_ff @(posedge clk) begin
		if (reset) begin
			key_data          <= '0;
			extended_key_data <= '0;
		end else if (key_event_valid) begin
			if (key_event.extended) begin
				extended_key_data[key_event.index] <= key_pressed;
			end else begin
				key_data[key_event.index] <= key_pressed;
			end
		end
	end

	// A valid event must name a defined key and map.
	a_event_known: assert property (@(posedge clk) disable iff (reset)
		key_event_valid |-> !$isunknown(key_event))
		else $error("Key event with unknown fields.");

endmodule

`default_nettype wire

//--- source/keyboard_parser.sv
`timescale 1ns/1ns
`default_nettype none

module keyboard_parser #(
	parameter int FILTER_DEPTH = 4
) (
	input  wire               clk,
	input  wire               reset,
	input  wire               ps2_clk,
	input  wire               ps2_data,
	output kbd_pkg::key_map_t key_data,
	output kbd_pkg::key_map_t extended_key_data,
	output logic              frame_error
);
	import kbd_pkg::*;

	scan_code_t scan_code;
	logic       scan_code_valid;
	key_event_t key_event;
	logic       key_event_valid;

	ps2_receiver #(
		.FILTER_DEPTH(FILTER_DEPTH)
	) i_ps2_receiver (
		.clk             (clk),
		.reset           (reset),
		.ps2_clk         (ps2_clk),
		.ps2_data        (ps2_data),
		.scan_code       (scan_code),
		.scan_code_valid (scan_code_valid),
		.frame_error     (frame_error) // Bad frames are reported, not decoded.
	);

	scan_code_parser i_scan_code_parser (
		.clk             (clk),
		.reset           (reset),
		.scan_code_valid (scan_code_valid),
		.scan_code       (scan_code),
		.key_event       (key_event),
		.key_event_valid (key_event_valid)
	);

	key_state_table i_key_state_table (
		.clk               (clk),
		.reset             (reset),
		.key_event_valid   (key_event_valid),
		.key_event         (key_event),
		.key_data          (key_data),
		.extended_key_data (extended_key_data)
	);

endmodule

`default_nettype wire

//--- source/ps2_receiver.sv
`timescale 1ns/1ns
`default_nettype none

module ps2_receiver #(
	parameter int FILTER_DEPTH = 4
) (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 ps2_clk,
	input  wire                 ps2_data,
	output kbd_pkg::scan_code_t scan_code,
	output logic                scan_code_valid,
	output logic                frame_error
);
	import kbd_pkg::*;

	localparam int COUNT_WIDTH = $clog2(PS2_FRAME_BITS);
	localparam int START_BIT   = 0;
	localparam int PARITY_BIT  = PS2_FRAME_BITS - 2;
	localparam int STOP_BIT    = PS2_FRAME_BITS - 1;
	localparam logic [COUNT_WIDTH-1:0] LAST_BIT = COUNT_WIDTH'(PS2_FRAME_BITS - 1);

	logic [1:0]                ps2_clk_sync;
	logic [1:0]                ps2_data_sync;
	logic [FILTER_DEPTH-1:0]   clk_history;
	logic                      clk_filtered;
	logic                      clk_fall;
	logic [PS2_FRAME_BITS-1:0] frame_bits;
	logic [COUNT_WIDTH-1:0]    bit_count;
	logic                      frame_done;
	logic                      frame_ok;

	if (FILTER_DEPTH < 2) begin : g_depth_check
		$error("FILTER_DEPTH must be at least 2.");
	end

	// Both lines idle high, so the synchronizers start there too.
	always_ff @(posedge clk) begin
		if (reset) begin
			ps2_clk_sync  <= 2'b11;
			ps2_data_sync <= 2'b11;
			clk_history   <= '1;
		end else begin
			ps2_clk_sync  <= {ps2_clk_sync[0], ps2_clk};
			ps2_data_sync <= {ps2_data_sync[0], ps2_data};
			clk_history   <= {clk_history[FILTER_DEPTH-2:0], ps2_clk_sync[1]};
		end
	end

	// The filtered clock only follows a level held for FILTER_DEPTH samples.
	always_ff @(posedge clk) begin
		if (reset) begin
			clk_filtered <= 1'b1;
		end else if (clk_history == '1) begin
			clk_filtered <= 1'b1;
		end else if (clk_history == '0) begin
			clk_filtered <= 1'b0;
		end
	end

	assign clk_fall = clk_filtered && (clk_history == '0); // Stable high to stable low.

	always_ff @(posedge clk) begin
		if (reset) begin
			bit_count  <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (clk_fall) begin
				if (bit_count == LAST_BIT) begin
					bit_count  <= '0;
					frame_done <= 1'b1; // Stop bit is in.
				end else begin
					bit_count <= bit_count + 1'b1;
				end
			end
		end
	end

	// LSB first, so new bits enter at the top and walk down.
	always_ff @(posedge clk) begin
		if (clk_fall) begin
			frame_bits <= {ps2_data_sync[1], frame_bits[PS2_FRAME_BITS-1:1]};
		end
	end

	// Odd parity covers the data byte and the parity bit.
	assign frame_ok = !frame_bits[START_BIT]
		&& (^frame_bits[PARITY_BIT:START_BIT+1])
		&& frame_bits[STOP_BIT];

	assign scan_code       = frame_bits[$bits(scan_code_t):START_BIT+1];
	assign scan_code_valid = frame_done && frame_ok;
	assign frame_error     = frame_done && !frame_ok;

	a_one_outcome: assert property (@(posedge clk) disable iff (reset)
		!(scan_code_valid && frame_error))
		else $error("Frame reported as both good and bad.");

endmodule

`default_nettype wire

//--- source/scan_code_parser.sv
`timescale 1ns/1ns
`default_nettype none

module scan_code_parser (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 scan_code_valid,
	input  wire kbd_pkg::scan_code_t scan_code,
	output kbd_pkg::key_event_t key_event,
	output logic                key_event_valid
);
	import kbd_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_EXTENDED,
		ST_BREAK
	} parser_state_t;

	parser_state_t state;
	logic          extended_seen;
	logic          break_seen;
	logic          is_prefix;
	logic          sequence_end;

	// E0 only counts as a prefix at the start, F0 also after E0.
	always_comb begin
		case (state)
			ST_IDLE:     is_prefix = (scan_code == PREFIX_EXTENDED) || (scan_code == PREFIX_BREAK);
			ST_EXTENDED: is_prefix = (scan_code == PREFIX_BREAK);
			default:     is_prefix = 1'b0; // After F0 any byte completes.
		endcase
	end

	assign sequence_end = scan_code_valid && !is_prefix;

	always_ff @(posedge clk) begin
		if (reset) begin
			state           <= ST_IDLE;
			extended_seen   <= 1'b0;
			break_seen      <= 1'b0;
			key_event_valid <= 1'b0;
		end else begin
			key_event_valid <= sequence_end && !scan_code[7]; // High codes are dropped.
			if (sequence_end) begin
				state         <= ST_IDLE;
				extended_seen <= 1'b0;
				break_seen    <= 1'b0;
			end else if (scan_code_valid) begin
				if (scan_code == PREFIX_BREAK) begin
					state      <= ST_BREAK;
					break_seen <= 1'b1;
				end else begin
					state         <= ST_EXTENDED;
					extended_seen <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sequence_end) begin
			key_event.index    <= key_index_t'(scan_code);
			key_event.extended <= extended_seen;
			key_event.released <= break_seen;
		end
	end

	a_event_follows_code: assert property (@(posedge clk) disable iff (reset)
		key_event_valid |-> $past(scan_code_valid))
		else $error("Key event without a preceding scan code.");

endmodule

`default_nettype wire

//--- verification/ps2_device_model.sv
`timescale 1ns/1ns
`default_nettype none

module ps2_device_model #(
	parameter int HALF_PERIOD = 10
) (
	input  wire       clk,
	input  wire       start,
	input  wire [7:0] tx_byte,
	input  wire       bad_parity,
	output logic      ps2_clk,
	output logic      ps2_data,
	output logic      done
);
	import kbd_pkg::*;

	task automatic wait_half_period();
		repeat (HALF_PERIOD) @(negedge clk);
	endtask

	// Data changes while the clock is high, the host samples it on the fall.
	task automatic send_frame(input logic [7:0] value, input logic invert_parity);
		logic [PS2_FRAME_BITS-1:0] frame;
		frame = {1'b1, (~^value) ^ invert_parity, value, 1'b0}; // Stop, parity, data, start.
		for (int i = 0; i < PS2_FRAME_BITS; i++) begin
			ps2_data = frame[i];
			wait_half_period();
			ps2_clk = 1'b0;
			wait_half_period();
			ps2_clk = 1'b1;
		end
		ps2_data = 1'b1;
		wait_half_period(); // Idle gap between frames.
		wait_half_period();
	endtask

	initial begin
		ps2_clk  = 1'b1;
		ps2_data = 1'b1;
		done     = 1'b1;
		forever begin
			@(posedge clk);
			if (start && done) begin
				done = 1'b0;
				send_frame(tx_byte, bad_parity);
				done = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verification/tb_keyboard_parser.sv
`timescale 1ns/1ns
`default_nettype none

module tb_keyboard_parser;
	import kbd_pkg::*;

	localparam int FILTER_DEPTH = 4;
	localparam int HALF_PERIOD  = 10;
	localparam int START_LIMIT  = 10;
	localparam int FRAME_LIMIT  = 1000;
	localparam int MATCH_LIMIT  = 2000;
	localparam int CHECK_LIMIT  = 2100;

	logic       clk;
	logic       reset;
	logic       ps2_clk;
	logic       ps2_data;
	logic       frame_error;
	key_map_t   key_data;
	key_map_t   extended_key_data;
	logic       dev_start;
	logic [7:0] dev_byte;
	logic       dev_bad;
	logic       dev_done;

	key_map_t   exp_key_data      = '0;
	key_map_t   exp_extended_data = '0;
	logic [7:0] seq_q[$];
	string      current_test      = "none";
	int         errors            = 0;
	int         tests             = 0;
	int         test_start_errors = 0;
	int         check_requests    = 0;
	int         checks_done       = 0;
	int         frame_errors      = 0;

	keyboard_parser #(
		.FILTER_DEPTH(FILTER_DEPTH)
	) i_keyboard_parser (
		.clk               (clk),
		.reset             (reset),
		.ps2_clk           (ps2_clk),
		.ps2_data          (ps2_data),
		.key_data          (key_data),
		.extended_key_data (extended_key_data),
		.frame_error       (frame_error)
	);

	ps2_device_model #(
		.HALF_PERIOD(HALF_PERIOD)
	) i_ps2_device_model (
		.clk        (clk),
		.start      (dev_start),
		.tx_byte    (dev_byte),
		.bad_parity (dev_bad),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.done       (dev_done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Make, break and extended rules applied to one byte sequence.
	function automatic void apply_reference(input logic [7:0] codes[$]);
		logic ext;
		logic brk;
		ext = 1'b0;
		brk = 1'b0;
		foreach (codes[i]) begin
			if (codes[i] == PREFIX_EXTENDED && !ext && !brk) begin
				ext = 1'b1;
			end else if (codes[i] == PREFIX_BREAK && !brk) begin
				brk = 1'b1;
			end else begin
				if (codes[i] < 8'h80) begin
					if (ext)
						exp_extended_data[codes[i][6:0]] = !brk;
					else
						exp_key_data[codes[i][6:0]] = !brk;
				end
				ext = 1'b0; // Any other byte ends the sequence.
				brk = 1'b0;
			end
		end
	endfunction

	function automatic logic maps_match();
		return (key_data === exp_key_data) && (extended_key_data === exp_extended_data);
	endfunction

	always @(negedge clk) begin
		if (!reset && frame_error)
			frame_errors++;
	end

	initial begin : compare_maps
		int cycles;
		forever begin
			@(negedge clk);
			if (checks_done != check_requests) begin
				cycles = 0;
				while (!maps_match() && cycles < MATCH_LIMIT) begin
					@(negedge clk);
					cycles++;
				end
				if (!maps_match()) begin
					$display("ERR %0t ns: %s, key maps differ from the reference", $time,
						current_test);
					$display("    key_data %h expected %h", key_data, exp_key_data);
					$display("    extended %h expected %h", extended_key_data,
						exp_extended_data);
					errors++;
				end
				checks_done++;
			end
		end
	end

	task automatic send_byte(input logic [7:0] value, input logic corrupt);
		int cycles;
		dev_byte  = value;
		dev_bad   = corrupt;
		dev_start = 1'b1;
		cycles = 0;
		while (dev_done) begin
			if (cycles == START_LIMIT) begin
				$display("Timeout: the PS/2 device model never started byte %h.", value);
				$display("Simulation FAILED");
				$finish;
			end
			@(negedge clk);
			cycles++;
		end
		dev_start = 1'b0;
		cycles = 0;
		while (!dev_done) begin
			if (cycles == FRAME_LIMIT) begin
				$display("Timeout: the PS/2 device model never finished byte %h.", value);
				$display("Simulation FAILED");
				$finish;
			end
			@(negedge clk);
			cycles++;
		end
	endtask

	task automatic check_maps();
		int cycles;
		check_requests++;
		cycles = 0;
		while (checks_done != check_requests) begin
			if (cycles == CHECK_LIMIT) begin
				$display("Timeout: the map compare did not answer in %s.", current_test);
				$display("Simulation FAILED");
				$finish;
			end
			@(negedge clk);
			cycles++;
		end
	endtask

	// Bad frames never reach the parser, so they stay out of the reference.
	task automatic send_sequence(input logic corrupt);
		foreach (seq_q[i])
			send_byte(seq_q[i], corrupt);
		if (!corrupt)
			apply_reference(seq_q);
		check_maps();
		seq_q.delete();
	endtask

	task automatic send_key(input logic [7:0] code, input logic ext, input logic rel);
		if (ext)
			seq_q.push_back(PREFIX_EXTENDED);
		if (rel)
			seq_q.push_back(PREFIX_BREAK);
		seq_q.push_back(code);
		send_sequence(1'b0);
	endtask

	task automatic start_test(input string name);
		current_test      = name;
		test_start_errors = errors;
		tests++;
	endtask

	task automatic finish_test();
		if (errors == test_start_errors)
			$display("Test %s: ok", current_test);
		else
			$display("Test %s: %0d error(s)", current_test, errors - test_start_errors);
	endtask

	initial begin : main
		logic [7:0] code;
		logic       ext;
		logic       rel;
		int         frame_errors_before;
		void'($urandom(7));
		reset     = 1'b1;
		dev_start = 1'b0;
		dev_byte  = 8'h00;
		dev_bad   = 1'b0;
		repeat (10) @(negedge clk);
		reset = 1'b0;

		start_test("reset");
		if (key_data !== '0 || extended_key_data !== '0) begin
			$display("ERR %0t ns: key maps not cleared by reset", $time);
			errors++;
		end
		repeat (20) @(negedge clk);
		if (frame_errors != 0) begin
			$display("ERR %0t ns: frame_error pulsed on idle lines", $time);
			errors++;
		end
		check_maps();
		finish_test();

		start_test("ordinary keys");
		send_key(8'h1C, 1'b0, 1'b0);
		send_key(8'h00, 1'b0, 1'b0);
		send_key(8'h7F, 1'b0, 1'b0);
		send_key(8'h1C, 1'b0, 1'b1);
		send_key(8'h00, 1'b0, 1'b1);
		send_key(8'h7F, 1'b0, 1'b1);
		finish_test();

		start_test("extended keys");
		send_key(8'h75, 1'b1, 1'b0);
		send_key(8'h75, 1'b0, 1'b0); // Same code, other map.
		send_key(8'h75, 1'b1, 1'b1);
		send_key(8'h75, 1'b0, 1'b1);
		finish_test();

		start_test("ignored codes");
		send_key(8'h08, 1'b0, 1'b0); // Held, so a decoded F0 88 would clear it.
		send_key(8'h7F, 1'b1, 1'b0); // Held, so a decoded E0 F0 FF would clear it.
		send_key(8'h83, 1'b0, 1'b0);
		send_key(8'hAA, 1'b0, 1'b0);
		send_key(8'hFE, 1'b0, 1'b0);
		send_key(8'h90, 1'b1, 1'b0);
		send_key(8'h88, 1'b0, 1'b1);
		send_key(8'hFF, 1'b1, 1'b1);
		send_key(8'h4B, 1'b0, 1'b0);
		send_key(8'h08, 1'b0, 1'b1);
		send_key(8'h7F, 1'b1, 1'b1);
		send_key(8'h4B, 1'b0, 1'b1);
		finish_test();

		start_test("bad parity");
		send_key(8'h33, 1'b0, 1'b0);
		frame_errors_before = frame_errors;
		seq_q.push_back(8'h1C);
		send_sequence(1'b1);
		if (frame_errors != frame_errors_before + 1) begin
			$display("ERR %0t ns: %0d frame errors counted, expected 1", $time,
				frame_errors - frame_errors_before);
			errors++;
		end
		send_key(8'h1C, 1'b0, 1'b0);
		send_key(8'h1C, 1'b0, 1'b1);
		send_key(8'h33, 1'b0, 1'b1);
		finish_test();

		start_test("random run");
		for (int n = 0; n < 200; n++) begin
			code = 8'($urandom % 16) | ((($urandom % 2) != 0) ? 8'h70 : 8'h00);
			ext  = 1'($urandom % 2);
			rel  = 1'($urandom % 2);
			send_key(code, ext, rel);
		end
		finish_test();

		$display("Tests: %0d, checks: %0d, errors: %0d, frame errors: %0d",
			tests, check_requests, errors, frame_errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire
